// File: sdr_ctrl_top.f
+incdir+rtl
rtl/sdr_ctrl_pkg.sv
rtl/sdr_req_queue.sv
rtl/sdr_port_arbiter.sv
rtl/sdr_refresh_timer.sv
rtl/sdr_cmd_fsm.sv
rtl/sdr_data_path.sv
rtl/sdr_ctrl_top.sv
verif/sdr_ctrl_tb.sv

// File: verif/sdr_ctrl_tb.sv
`timescale 1ns/1ps
`include "sdr_ctrl_consts.svh"

module sdr_ctrl_tb
   import sdr_ctrl_pkg::*;
();

   localparam int NR         = `SDR_NR_PORTS;
   localparam int DEPTH      = `SDR_QUEUE_DEPTH;
   localparam int NR_REQS    = 40;
   localparam int PIPE       = `SDR_CL + 2;
   localparam int ACCESS_CYC = `SDR_TRCD + `SDR_TRP + 6;
   localparam int REF_WINDOW = `SDR_REF_INTERVAL + ACCESS_CYC;
   localparam int WATCHDOG   =
      2 * (`SDR_INIT_WAIT + 60 + NR_REQS * (ACCESS_CYC + `SDR_TRFC + 2));
   localparam sdr_cmd_e INIT_SEQ [4] = '{CMD_PRECHARGE, CMD_AREF, CMD_AREF, CMD_LMR};

   logic                  sdram_clk = 1'b0;
   logic                  sdram_rst;
   sdr_port_vec_t         req_valid;
   sdr_req_arr_t          req;
   sdr_port_vec_t         credit;
   logic                  resp_valid;
   sdr_resp_t             resp;
   sdr_pad_t              pad;
   logic [15:0]           dq_o;
   logic [1:0]            dqm;
   logic                  dq_oe;
   logic [15:0]           dq_i;

   logic [31:0]           lfsr = 32'hcfc4_ef31;
   logic                  run = 1'b0;
   int                    errors;
   int                    issued;
   int                    cmd_count;
   int                    since_aref;
   int                    credits [NR];
   int                    served [NR];
   sdr_req_t              pend [NR][$];
   sdr_resp_t             exp_resp [$];
   sdr_req_t              cur;
   sdr_port_t             cur_port;
   logic [`SDR_ROW_W-1:0] act_row;
   logic                  wr_next;
   logic                  rd_vld [PIPE];
   logic [31:0]           rd_word [PIPE];

   always #50 sdram_clk = ~sdram_clk;

   sdr_ctrl_top u_dut (
      .sdram_clk    (sdram_clk),
      .sdram_rst    (sdram_rst),
      .req_valid_i  (req_valid),
      .req_i        (req),
      .credit_o     (credit),
      .resp_valid_o (resp_valid),
      .resp_o       (resp),
      .pad_o        (pad),
      .dq_o         (dq_o),
      .dqm_o        (dqm),
      .dq_oe_o      (dq_oe),
      .dq_i         (dq_i)
   );

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // Read data the memory model returns for a location
   function automatic logic [31:0] pattern_word(input logic [`SDR_BA_W-1:0] ba,
                                                input logic [`SDR_ROW_W-1:0] row,
                                                input logic [`SDR_COL_W-2:0] col);
      return {ba, row, col, ~ba, ~col[6:0]} ^ 32'h9e37_79b9;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic expect_true(input logic ok, input string what);
      assert (ok) else begin
         errors++;
         $display("Error: %s", what);
      end
   endtask

   function automatic logic work_left();
      logic busy;
      busy = (issued < NR_REQS) || (exp_resp.size() > 0) || wr_next;
      for (int i = 0; i < NR; i++) begin
         busy = busy || (pend[i].size() > 0) || (credits[i] != DEPTH);
      end
      return busy;
   endfunction

   // Credit accounting and request issue
   always @(negedge sdram_clk) begin : drive
      logic [31:0] bits;
      sdr_req_t    r;
      int          p;
      if (run) begin
         for (int i = 0; i < NR; i++) begin
            if (credit[i]) begin
               credits[i]++;
            end
            expect_true(credits[i] >= 0 && credits[i] <= DEPTH,
                        $sformatf("credit count of port %0d out of range", i));
         end
         req_valid = '0;
         if (issued < NR_REQS) begin
            take_bits(1, bits);
            p = int'(bits[0]);
            if (credits[p] > 0) begin
               take_bits(`SDR_BA_W, bits);
               r.ba = bits[`SDR_BA_W-1:0];
               take_bits(`SDR_ROW_W - 1, bits);
               // Row MSB tags the port
               r.row = {1'(p), bits[`SDR_ROW_W-2:0]};
               take_bits(`SDR_COL_W - 1, bits);
               r.col = bits[`SDR_COL_W-2:0];
               take_bits(1, bits);
               r.we = bits[0];
               take_bits(32, bits);
               r.wdata = bits;
               take_bits(4, bits);
               r.be = bits[3:0];
               req[p]       = r;
               req_valid[p] = 1'b1;
               credits[p]--;
               pend[p].push_back(r);
               issued++;
            end
         end
      end
   end

   // Pin monitor, read responder and response check
   always @(negedge sdram_clk) begin : monitor
      sdr_resp_t e;
      int        p;
      if (run) begin
         for (int i = PIPE - 1; i > 0; i--) begin
            rd_vld[i]  = rd_vld[i-1];
            rd_word[i] = rd_word[i-1];
         end
         rd_vld[0] = 1'b0;
         since_aref++;
         if (pad.cmd == CMD_AREF) begin
            since_aref = 0;
         end
         expect_true(since_aref <= REF_WINDOW, "no AREF within the refresh window");
         compare_value("pad_o.cs_n", pad.cs_n, 1'b0);
         compare_value("pad_o.cke", pad.cke, 1'b1);
         if (!wr_next && pad.cmd != CMD_WRITE) begin
            compare_value("dq_oe_o", dq_oe, 1'b0);
         end
         if (wr_next) begin
            compare_value("dq_o", dq_o, cur.wdata[15:0]);
            compare_value("dqm_o", dqm, {~cur.be[1:0]});
            compare_value("dq_oe_o", dq_oe, 1'b1);
            wr_next = 1'b0;
         end
         if (pad.cmd != CMD_NOP && cmd_count < 4) begin
            compare_value("pad_o.cmd", pad.cmd, INIT_SEQ[cmd_count]);
            if (pad.cmd == CMD_LMR) begin
               // CAS latency, sequential, burst of 2
               compare_value("pad_o.addr[6:4]", pad.addr[6:4], `SDR_CL);
               compare_value("pad_o.addr[3:0]", pad.addr[3:0], 4'b0001);
            end
            cmd_count++;
         end else if (pad.cmd == CMD_ACTIVE) begin
            p = int'(pad.addr[`SDR_ROW_W-1]);
            expect_true(pend[p].size() > 0, "ACTIVE for a port with nothing queued");
            if (pend[p].size() > 0) begin
               cur      = pend[p].pop_front();
               cur_port = sdr_port_t'(p);
               act_row  = pad.addr;
               served[p]++;
               compare_value("pad_o.ba", pad.ba, cur.ba);
               compare_value("pad_o.addr", pad.addr, cur.row);
            end
         end else if (pad.cmd inside {CMD_READ, CMD_WRITE}) begin
            compare_value("pad_o.cmd", pad.cmd, cur.we ? CMD_WRITE : CMD_READ);
            compare_value("pad_o.ba", pad.ba, cur.ba);
            compare_value("pad_o.addr", pad.addr, {cur.col, 1'b0});
            if (pad.cmd == CMD_WRITE) begin
               compare_value("dq_o", dq_o, cur.wdata[31:16]);
               compare_value("dqm_o", dqm, {~cur.be[3:2]});
               compare_value("dq_oe_o", dq_oe, 1'b1);
               wr_next = 1'b1;
            end else begin
               rd_vld[0]  = 1'b1;
               rd_word[0] = pattern_word(pad.ba, act_row, pad.addr[`SDR_COL_W-1:1]);
               e.port     = cur_port;
               e.rdata    = pattern_word(cur.ba, cur.row, cur.col);
               exp_resp.push_back(e);
            end
         end else if (pad.cmd == CMD_PRECHARGE) begin
            // Single-bank precharge of the bank just accessed
            compare_value("pad_o.ba", pad.ba, cur.ba);
            compare_value("pad_o.addr[10]", pad.addr[10], 1'b0);
         end
         // Upper half first, then lower half
         if (rd_vld[`SDR_CL]) begin
            dq_i = rd_word[`SDR_CL][31:16];
         end else if (rd_vld[`SDR_CL + 1]) begin
            dq_i = rd_word[`SDR_CL + 1][15:0];
         end else begin
            dq_i = 16'hdead;
         end
         if (resp_valid) begin
            expect_true(exp_resp.size() > 0, "response with no READ outstanding");
            if (exp_resp.size() > 0) begin
               e = exp_resp.pop_front();
               compare_value("resp_o.port", resp.port, e.port);
               compare_value("resp_o.rdata", resp.rdata, e.rdata);
            end
         end
      end
   end

   a_read_latency: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (pad.cmd == CMD_READ) |-> ##(`SDR_CL + 2) resp_valid)
      else begin
         errors++;
         $display("Error: resp_valid_o missing %0d cycles after READ", `SDR_CL + 2);
      end

   a_resp_after_read: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      resp_valid |-> $past(pad.cmd == CMD_READ, `SDR_CL + 2))
      else begin
         errors++;
         $display("Error: resp_valid_o without a READ %0d cycles before", `SDR_CL + 2);
      end

   a_no_active_in_trfc: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (pad.cmd == CMD_AREF) |=> (pad.cmd != CMD_ACTIVE)[*`SDR_TRFC])
      else begin
         errors++;
         $display("Error: ACTIVE issued within tRFC of AREF");
      end

   initial begin
      sdram_rst = 1'b1;
      req_valid = '0;
      req       = '{default: '0};
      dq_i      = 16'hdead;
      wr_next   = 1'b0;
      for (int i = 0; i < NR; i++) begin
         credits[i] = DEPTH;
      end
      for (int i = 0; i < PIPE; i++) begin
         rd_vld[i] = 1'b0;
      end
      repeat (10) @(posedge sdram_clk);
      @(negedge sdram_clk);
      sdram_rst = 1'b0;
      @(posedge sdram_clk);
      run = 1'b1;
      while (work_left()) begin
         @(posedge sdram_clk);
      end
      // Quiet period to catch stray credits or responses
      repeat (20) @(posedge sdram_clk);
      for (int i = 0; i < NR; i++) begin
         expect_true(served[i] > 0, $sformatf("port %0d was never served", i));
         compare_value($sformatf("credit_o count port %0d", i), credits[i], DEPTH);
      end
      expect_true(cmd_count >= 4, "initialisation sequence incomplete");
      $display("Requests: %0d, errors: %0d", issued, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG) @(posedge sdram_clk);
      $display("Timeout after %0d cycles, errors: %0d", WATCHDOG, errors);
      $display("TB FAILED");
      $finish;
   end

endmodule

// File: rtl/sdr_ctrl_top.sv
`timescale 1ns/1ps

module sdr_ctrl_top
   import sdr_ctrl_pkg::*;
(
   input  logic          sdram_clk,
   input  logic          sdram_rst,
   input  sdr_port_vec_t req_valid_i,
   input  sdr_req_arr_t  req_i,
   output sdr_port_vec_t credit_o,
   output logic          resp_valid_o,
   output sdr_resp_t     resp_o,
   output sdr_pad_t      pad_o,
   output logic [15:0]   dq_o,
   output logic [1:0]    dqm_o,
   output logic          dq_oe_o,
   input  logic [15:0]   dq_i
);

   sdr_req_arr_t  head;
   sdr_port_vec_t empty;
   sdr_port_vec_t pop;
   logic          grant_valid;
   sdr_req_t      grant;
   sdr_port_t     grant_port;
   logic          take;
   logic          ref_req;
   logic          ref_done;
   sdr_req_t      cur_req;
   sdr_port_t     cur_port;
   logic          wr_beat;
   logic          wr_active;
   logic          rd_issue;

   for (genvar p = 0; p < $bits(sdr_port_vec_t); p++) begin : g_queue
      sdr_req_queue u_queue (
         .sdram_clk   (sdram_clk),
         .sdram_rst   (sdram_rst),
         .push_i      (req_valid_i[p]),
         .push_data_i (req_i[p]),
         .pop_i       (pop[p]),
         .head_o      (head[p]),
         .empty_o     (empty[p]),
         .credit_o    (credit_o[p])
      );
   end

   sdr_port_arbiter u_arbiter (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .head_i        (head),
      .empty_i       (empty),
      .take_i        (take),
      .grant_valid_o (grant_valid),
      .grant_o       (grant),
      .grant_port_o  (grant_port),
      .pop_o         (pop)
   );

   sdr_refresh_timer u_refresh (
      .sdram_clk  (sdram_clk),
      .sdram_rst  (sdram_rst),
      .ref_done_i (ref_done),
      .ref_req_o  (ref_req)
   );

   sdr_cmd_fsm u_fsm (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .grant_valid_i (grant_valid),
      .grant_i       (grant),
      .grant_port_i  (grant_port),
      .take_o        (take),
      .ref_req_i     (ref_req),
      .ref_done_o    (ref_done),
      .pad_o         (pad_o),
      .cur_req_o     (cur_req),
      .cur_port_o    (cur_port),
      .wr_beat_o     (wr_beat),
      .wr_active_o   (wr_active),
      .rd_issue_o    (rd_issue)
   );

   sdr_data_path u_data (
      .sdram_clk    (sdram_clk),
      .sdram_rst    (sdram_rst),
      .cur_req_i    (cur_req),
      .cur_port_i   (cur_port),
      .wr_active_i  (wr_active),
      .wr_beat_i    (wr_beat),
      .rd_issue_i   (rd_issue),
      .dq_i         (dq_i),
      .dq_o         (dq_o),
      .dqm_o        (dqm_o),
      .dq_oe_o      (dq_oe_o),
      .resp_valid_o (resp_valid_o),
      .resp_o       (resp_o)
   );

endmodule

// File: rtl/sdr_data_path.sv
`timescale 1ns/1ps
`include "sdr_ctrl_consts.svh"

module sdr_data_path
   import sdr_ctrl_pkg::*;
(
   input  logic        sdram_clk,
   input  logic        sdram_rst,
   input  sdr_req_t    cur_req_i,
   input  sdr_port_t   cur_port_i,
   input  logic        wr_active_i,
   input  logic        wr_beat_i,
   input  logic        rd_issue_i,
   input  logic [15:0] dq_i,
   output logic [15:0] dq_o,
   output logic [1:0]  dqm_o,
   output logic        dq_oe_o,
   output logic        resp_valid_o,
   output sdr_resp_t   resp_o
);

   localparam int CL = `SDR_CL;

   logic [CL-1:0] rd_vld_q;
   sdr_port_t     rd_port_q [CL];
   logic          beat1_q;
   sdr_port_t     beat1_port_q;
   logic [15:0]   beat0_q;

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         dq_oe_o      <= 1'b0;
         dqm_o        <= '0;
         rd_vld_q     <= '0;
         beat1_q      <= 1'b0;
         resp_valid_o <= 1'b0;
      end else begin
         dq_oe_o <= wr_active_i;
         // Reads and idle cycles stay unmasked
         if (!wr_active_i) begin
            dqm_o <= '0;
         end else if (wr_beat_i) begin
            dqm_o <= ~cur_req_i.be[1:0];
         end else begin
            dqm_o <= ~cur_req_i.be[3:2];
         end
         rd_vld_q     <= {rd_vld_q[CL-2:0], rd_issue_i};
         beat1_q      <= rd_vld_q[CL-1];
         resp_valid_o <= beat1_q;
      end
   end

   always_ff @(posedge sdram_clk) begin
      dq_o <= wr_beat_i ? cur_req_i.wdata[15:0] : cur_req_i.wdata[31:16];
      rd_port_q[0] <= cur_port_i;
      for (int k = 1; k < CL; k++) begin
         rd_port_q[k] <= rd_port_q[k-1];
      end
      // Beat 0 is the upper half
      if (rd_vld_q[CL-1]) begin
         beat0_q      <= dq_i;
         beat1_port_q <= rd_port_q[CL-1];
      end
      if (beat1_q) begin
         resp_o.rdata <= {beat0_q, dq_i};
         resp_o.port  <= beat1_port_q;
      end
   end

endmodule

// File: rtl/sdr_cmd_fsm.sv
`timescale 1ns/1ps
`include "sdr_ctrl_consts.svh"

module sdr_cmd_fsm
   import sdr_ctrl_pkg::*;
(
   input  logic      sdram_clk,
   input  logic      sdram_rst,
   input  logic      grant_valid_i,
   input  sdr_req_t  grant_i,
   input  sdr_port_t grant_port_i,
   output logic      take_o,
   input  logic      ref_req_i,
   output logic      ref_done_o,
   output sdr_pad_t  pad_o,
   output sdr_req_t  cur_req_o,
   output sdr_port_t cur_port_o,
   output logic      wr_beat_o,
   output logic      wr_active_o,
   output logic      rd_issue_o
);

   localparam int CNT_W = $clog2(`SDR_INIT_WAIT);

   // Burst length 2, sequential, CAS latency in A6..A4
   localparam logic [`SDR_ROW_W-1:0] LMR_MODE =
      `SDR_ROW_W'({6'b000000, 3'(`SDR_CL), 1'b0, 3'b001});

   sdr_state_e       state_q, state_d;
   sdr_state_e       ret_q, ret_d;
   logic [CNT_W-1:0] wait_q, wait_d;
   sdr_req_t         cur_req_q, req_d;
   sdr_port_t        cur_port_q;
   sdr_pad_t         pad_d;

   assign take_o     = (state_q == ST_IDLE) && !ref_req_i && grant_valid_i;
   assign ref_done_o = (state_q == ST_REF);
   assign req_d      = take_o ? grant_i : cur_req_q;

   always_comb begin
      state_d = state_q;
      wait_d  = wait_q;
      ret_d   = ret_q;
      case (state_q)
         ST_INIT_WAIT, ST_WAIT: begin
            if (wait_q == '0) begin
               state_d = ret_q;
            end else begin
               wait_d = wait_q - 1'b1;
            end
         end
         ST_INIT_PRE: begin
            state_d = ST_WAIT;
            wait_d  = CNT_W'(`SDR_TRP - 1);
            ret_d   = ST_INIT_REF1;
         end
         ST_INIT_REF1: begin
            state_d = ST_WAIT;
            wait_d  = CNT_W'(`SDR_TRFC - 1);
            ret_d   = ST_INIT_REF2;
         end
         ST_INIT_REF2: begin
            state_d = ST_WAIT;
            wait_d  = CNT_W'(`SDR_TRFC - 1);
            ret_d   = ST_INIT_LMR;
         end
         ST_INIT_LMR: begin
            state_d = ST_WAIT;
            wait_d  = CNT_W'(`SDR_TMRD - 1);
            ret_d   = ST_IDLE;
         end
         ST_IDLE: begin
            // Refresh wins over a pending grant
            if (ref_req_i) begin
               state_d = ST_REF;
            end else if (grant_valid_i) begin
               state_d = ST_ACT;
            end
         end
         ST_ACT: begin
            state_d = ST_WAIT;
            wait_d  = CNT_W'(`SDR_TRCD - 1);
            ret_d   = ST_RW;
         end
         ST_RW: begin
            state_d = ST_WAIT;
            wait_d  = '0;
            ret_d   = ST_PRE;
         end
         ST_PRE: begin
            state_d = ST_WAIT;
            wait_d  = CNT_W'(`SDR_TRP - 1);
            ret_d   = ST_IDLE;
         end
         ST_REF: begin
            state_d = ST_WAIT;
            wait_d  = CNT_W'(`SDR_TRFC - 1);
            ret_d   = ST_IDLE;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   // Pins carry the command of the state being entered
   always_comb begin
      pad_d.cs_n = 1'b0;
      pad_d.cke  = 1'b1;
      pad_d.cmd  = CMD_NOP;
      pad_d.ba   = '0;
      pad_d.addr = '0;
      case (state_d)
         ST_INIT_PRE: begin
            pad_d.cmd      = CMD_PRECHARGE;
            pad_d.addr[10] = 1'b1;
         end
         ST_INIT_REF1, ST_INIT_REF2, ST_REF: pad_d.cmd = CMD_AREF;
         ST_INIT_LMR: begin
            pad_d.cmd  = CMD_LMR;
            pad_d.addr = LMR_MODE;
         end
         ST_ACT: begin
            pad_d.cmd  = CMD_ACTIVE;
            pad_d.ba   = req_d.ba;
            pad_d.addr = req_d.row;
         end
         ST_RW: begin
            pad_d.cmd  = req_d.we ? CMD_WRITE : CMD_READ;
            pad_d.ba   = req_d.ba;
            pad_d.addr = `SDR_ROW_W'({req_d.col, 1'b0});
         end
         ST_PRE: begin
            pad_d.cmd = CMD_PRECHARGE;
            pad_d.ba  = req_d.ba;
         end
         default: ;
      endcase
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         state_q    <= ST_INIT_WAIT;
         ret_q      <= ST_INIT_PRE;
         wait_q     <= CNT_W'(`SDR_INIT_WAIT - 1);
         pad_o.cs_n <= 1'b0;
         pad_o.cke  <= 1'b1;
         pad_o.cmd  <= CMD_NOP;
         pad_o.ba   <= '0;
         pad_o.addr <= '0;
      end else begin
         state_q <= state_d;
         ret_q   <= ret_d;
         wait_q  <= wait_d;
         pad_o   <= pad_d;
      end
   end

   always_ff @(posedge sdram_clk) begin
      if (take_o) begin
         cur_req_q  <= grant_i;
         cur_port_q <= grant_port_i;
      end
   end

   assign cur_req_o  = cur_req_q;
   assign cur_port_o = cur_port_q;

   // Write strobes run one cycle ahead of the pins
   assign wr_active_o = cur_req_q.we && ((state_d == ST_RW) || (state_q == ST_RW));
   assign wr_beat_o   = (state_q == ST_RW);
   assign rd_issue_o  = (state_q == ST_RW) && !cur_req_q.we;

   a_trcd: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (pad_o.cmd == CMD_ACTIVE) |=>
         (!(pad_o.cmd inside {CMD_READ, CMD_WRITE}))[*(`SDR_TRCD - 1)]);

   a_trfc: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (pad_o.cmd == CMD_AREF) |=> (pad_o.cmd == CMD_NOP)[*`SDR_TRFC]);

endmodule

// File: rtl/sdr_refresh_timer.sv
`timescale 1ns/1ps
`include "sdr_ctrl_consts.svh"

module sdr_refresh_timer
   import sdr_ctrl_pkg::*;
(
   input  logic sdram_clk,
   input  logic sdram_rst,
   input  logic ref_done_i,
   output logic ref_req_o
);

   localparam int REF_W = $clog2(`SDR_REF_INTERVAL);

   logic [REF_W-1:0] cnt_q;

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         cnt_q     <= REF_W'(`SDR_REF_INTERVAL - 1);
         ref_req_o <= 1'b0;
      end else if (cnt_q == '0) begin
         cnt_q     <= REF_W'(`SDR_REF_INTERVAL - 1);
         ref_req_o <= 1'b1;
      end else begin
         cnt_q <= cnt_q - 1'b1;
         // Held until the sequencer has issued AREF
         if (ref_done_i) begin
            ref_req_o <= 1'b0;
         end
      end
   end

endmodule

// File: rtl/sdr_port_arbiter.sv
`timescale 1ns/1ps
`include "sdr_ctrl_consts.svh"

module sdr_port_arbiter
   import sdr_ctrl_pkg::*;
(
   input  logic          sdram_clk,
   input  logic          sdram_rst,
   input  sdr_req_arr_t  head_i,
   input  sdr_port_vec_t empty_i,
   input  logic          take_i,
   output logic          grant_valid_o,
   output sdr_req_t      grant_o,
   output sdr_port_t     grant_port_o,
   output sdr_port_vec_t pop_o
);

   localparam int NR = `SDR_NR_PORTS;

   sdr_port_t last_q;
   sdr_port_t sel;
   logic      found;

   // First non-empty queue after the one served last
   always_comb begin
      int idx;
      sel   = last_q;
      found = 1'b0;
      for (int i = 1; i <= NR; i++) begin
         idx = (int'(last_q) + i) % NR;
         if (!found && !empty_i[idx]) begin
            found = 1'b1;
            sel   = sdr_port_t'(idx);
         end
      end
   end

   assign grant_valid_o = found;
   assign grant_o       = head_i[sel];
   assign grant_port_o  = sel;
   assign pop_o         = (take_i && found) ? (sdr_port_vec_t'(1) << sel) : '0;

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         last_q <= sdr_port_t'(NR - 1);
      end else if (take_i && found) begin
         last_q <= sel;
      end
   end

   // One queue popped per take and none otherwise
   a_pop_legal: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      $onehot0(pop_o) && (!take_i || (pop_o != '0)));

endmodule

// File: rtl/sdr_req_queue.sv
`timescale 1ns/1ps
`include "sdr_ctrl_consts.svh"

module sdr_req_queue
   import sdr_ctrl_pkg::*;
(
   input  logic     sdram_clk,
   input  logic     sdram_rst,
   input  logic     push_i,
   input  sdr_req_t push_data_i,
   input  logic     pop_i,
   output sdr_req_t head_o,
   output logic     empty_o,
   output logic     credit_o
);

   localparam int DEPTH = `SDR_QUEUE_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   sdr_req_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             full;

   assign full    = (count == (PTR_W + 1)'(DEPTH));
   assign empty_o = (count == '0);
   assign head_o  = mem[rd_ptr];

   always_ff @(posedge sdram_clk) begin
      if (push_i) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end else begin
         if (push_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count    <= count + (PTR_W + 1)'(push_i) - (PTR_W + 1)'(pop_i);
         // Freed slot goes back to the requester
         credit_o <= pop_i;
      end
   end

   // Requester pushed without holding a credit
   a_no_overflow: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      !(push_i && full));

endmodule

// File: rtl/sdr_ctrl_pkg.sv
`include "sdr_ctrl_consts.svh"

package sdr_ctrl_pkg;

   typedef logic [`SDR_NR_PORTS-1:0]         sdr_port_vec_t;
   typedef logic [$clog2(`SDR_NR_PORTS)-1:0] sdr_port_t;

   // One 32-bit word access addressed by word column
   typedef struct packed {
      logic [`SDR_BA_W-1:0]  ba;
      logic [`SDR_ROW_W-1:0] row;
      logic [`SDR_COL_W-2:0] col;
      logic                  we;
      logic [31:0]           wdata;
      logic [3:0]            be;
   } sdr_req_t;

   typedef sdr_req_t sdr_req_arr_t [`SDR_NR_PORTS];

   typedef struct packed {
      sdr_port_t   port;
      logic [31:0] rdata;
   } sdr_resp_t;

   // Encoded as {ras_n, cas_n, we_n}
   typedef enum logic [2:0] {
      CMD_LMR       = 3'b000,
      CMD_AREF      = 3'b001,
      CMD_PRECHARGE = 3'b010,
      CMD_ACTIVE    = 3'b011,
      CMD_WRITE     = 3'b100,
      CMD_READ      = 3'b101,
      CMD_NOP       = 3'b111
   } sdr_cmd_e;

   typedef struct packed {
      logic                  cs_n;
      logic                  cke;
      sdr_cmd_e              cmd;
      logic [`SDR_BA_W-1:0]  ba;
      logic [`SDR_ROW_W-1:0] addr;
   } sdr_pad_t;

   typedef enum logic [3:0] {
      ST_INIT_WAIT,
      ST_INIT_PRE,
      ST_INIT_REF1,
      ST_INIT_REF2,
      ST_INIT_LMR,
      ST_IDLE,
      ST_ACT,
      ST_RW,
      ST_PRE,
      ST_REF,
      ST_WAIT
   } sdr_state_e;

endpackage

// File: rtl/sdr_ctrl_consts.svh
`ifndef SDR_CTRL_CONSTS_SVH
`define SDR_CTRL_CONSTS_SVH

// Device geometry
`define SDR_BA_W         2
`define SDR_ROW_W        13
`define SDR_COL_W        9

// CAS latency of 2 or 3
`define SDR_CL           2

// Command spacing in clock cycles
`define SDR_TRCD         2
`define SDR_TRP          2
`define SDR_TRFC         7
`define SDR_TMRD         2

// Idle time after power-up before the init sequence
`define SDR_INIT_WAIT    100

// Auto-refresh period
`define SDR_REF_INTERVAL 390

// Request queues
`define SDR_QUEUE_DEPTH  4
`define SDR_NR_PORTS     2

`endif
